//--- build.f
+incdir+logic
logic/llc_pkg.sv
logic/llc_region_decoder.sv
logic/llc_tag_store.sv
logic/llc_event_unit.sv
logic/llc_cfg_regs.sv
logic/llc_monitor_top.sv
tests/llc_checker.sv
tests/tb_llc_monitor.sv

//--- run.sh
#!/bin/sh
# Compile and run the LLC monitor testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_llc_monitor -o sim_llc
./obj_dir/sim_llc > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tests/tb_llc_monitor.sv
// LLC monitor testbench applying a table of config accesses and requests
`timescale 1ns/1ps
`include "llc_params.svh"

module tb_llc_monitor;
  import llc_pkg::*;

  localparam logic [1:0] KIND_CFG_WR = 2'd0;
  localparam logic [1:0] KIND_CFG_RD = 2'd1;
  localparam logic [1:0] KIND_REQ    = 2'd2;
  localparam int         MAX_ENTRIES = 128;

  typedef struct packed {
    logic [1:0]             kind;
    llc_cfg_reg_e           reg_idx;
    logic [`LLC_ADDR_W-1:0] data;
    logic [`LLC_ADDR_W-1:0] addr;
    logic                   we;
    llc_region_e            region;
    logic                   hit;
  } entry_t;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  logic [`LLC_ADDR_W-1:0] req_addr;
  logic                   req_we;
  logic                   resp_valid;
  llc_region_e            resp_region;
  logic                   resp_hit;
  logic                   credit;
  logic                   cfg_req_valid;
  logic                   cfg_we;
  llc_cfg_reg_e           cfg_addr;
  logic [`LLC_ADDR_W-1:0] cfg_wdata;
  logic                   cfg_resp_valid;
  logic [`LLC_ADDR_W-1:0] cfg_rdata;
  llc_region_e            exp_region;
  logic                   exp_hit;
  logic [`LLC_ADDR_W-1:0] exp_rdata;
  int                     value_errs;
  int                     proto_errs;
  int                     pending;

  entry_t                 stim [MAX_ENTRIES];
  int                     n_entries;
  int                     cycle = 0;
  int                     cycle_limit;
  int                     spent = 0;
  int                     returned = 0;
  integer                 seed;

  // Reference model of windows, tags and counters
  logic [`LLC_ADDR_W-1:0] m_cache_start;
  logic [`LLC_ADDR_W-1:0] m_cache_end;
  logic [`LLC_ADDR_W-1:0] m_spm_start;
  logic                   m_valid [`LLC_NUM_LINES];
  logic [`LLC_TAG_W-1:0]  m_tag [`LLC_NUM_LINES];
  logic [`LLC_CNT_W-1:0]  m_cnt [4];

  llc_monitor_top llc_monitor_top_i (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .req_valid_i      ( req_valid      ),
    .req_addr_i       ( req_addr       ),
    .req_we_i         ( req_we         ),
    .resp_valid_o     ( resp_valid     ),
    .resp_region_o    ( resp_region    ),
    .resp_hit_o       ( resp_hit       ),
    .credit_o         ( credit         ),
    .cfg_req_valid_i  ( cfg_req_valid  ),
    .cfg_we_i         ( cfg_we         ),
    .cfg_addr_i       ( cfg_addr       ),
    .cfg_wdata_i      ( cfg_wdata      ),
    .cfg_resp_valid_o ( cfg_resp_valid ),
    .cfg_rdata_o      ( cfg_rdata      )
  );

  llc_checker checker_i (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .req_valid_i      ( req_valid      ),
    .exp_region_i     ( exp_region     ),
    .exp_hit_i        ( exp_hit        ),
    .cfg_req_valid_i  ( cfg_req_valid  ),
    .cfg_we_i         ( cfg_we         ),
    .exp_rdata_i      ( exp_rdata      ),
    .resp_valid_i     ( resp_valid     ),
    .resp_region_i    ( resp_region    ),
    .resp_hit_i       ( resp_hit       ),
    .credit_i         ( credit         ),
    .cfg_resp_valid_i ( cfg_resp_valid ),
    .cfg_rdata_i      ( cfg_rdata      ),
    .value_errs_o     ( value_errs     ),
    .proto_errs_o     ( proto_errs     ),
    .pending_o        ( pending        )
  );

  always #10 clk = ~clk;

  // Credits come back mid-cycle
  always @(negedge clk) begin
    if (rst_n && (credit === 1'b1)) begin
      returned = returned + 1;
    end
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d responses outstanding", cycle, pending);
      $display("Errors: value %0d, protocol %0d", value_errs, proto_errs);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic llc_region_e classify_addr(input logic [`LLC_ADDR_W-1:0] addr);
    if ((addr >= m_spm_start) && ((addr - m_spm_start) < 32'(`LLC_SPM_SIZE))) begin
      return REGION_SPM;
    end else if ((addr >= m_cache_start) && (addr < m_cache_end)) begin
      return REGION_CACHED;
    end
    return REGION_BYPASS;
  endfunction

  task automatic write_register(input llc_cfg_reg_e idx, input logic [`LLC_ADDR_W-1:0] data);
    entry_t e;
    e = '0;
    e.kind = KIND_CFG_WR;
    e.reg_idx = idx;
    e.data = data;
    case (idx)
      REG_CACHE_START: m_cache_start = data;
      REG_CACHE_END:   m_cache_end = data;
      REG_SPM_START:   m_spm_start = data;
      REG_FLUSH: begin
        for (int i = 0; i < `LLC_NUM_LINES; i++) begin
          m_valid[i] = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
          m_cnt[i] = '0;
        end
      end
      default: begin
      end
    endcase
    stim[n_entries] = e;
    n_entries = n_entries + 1;
  endtask

  task automatic read_register(input llc_cfg_reg_e idx);
    entry_t e;
    e = '0;
    e.kind = KIND_CFG_RD;
    e.reg_idx = idx;
    case (idx)
      REG_CACHE_START: e.data = m_cache_start;
      REG_CACHE_END:   e.data = m_cache_end;
      REG_SPM_START:   e.data = m_spm_start;
      REG_READ_HIT:    e.data = m_cnt[0];
      REG_READ_MISS:   e.data = m_cnt[1];
      REG_WRITE_HIT:   e.data = m_cnt[2];
      REG_WRITE_MISS:  e.data = m_cnt[3];
      default:         e.data = '0;
    endcase
    stim[n_entries] = e;
    n_entries = n_entries + 1;
  endtask

  task automatic read_counters();
    read_register(REG_READ_HIT);
    read_register(REG_READ_MISS);
    read_register(REG_WRITE_HIT);
    read_register(REG_WRITE_MISS);
  endtask

  task automatic issue_request(input logic [`LLC_ADDR_W-1:0] addr, input logic we);
    entry_t                  e;
    logic [`LLC_INDEX_W-1:0] idx;
    logic [`LLC_TAG_W-1:0]   tag;
    e = '0;
    idx = addr[`LLC_OFFSET_W +: `LLC_INDEX_W];
    tag = addr[`LLC_ADDR_W-1 -: `LLC_TAG_W];
    e.kind = KIND_REQ;
    e.addr = addr;
    e.we = we;
    e.region = classify_addr(addr);
    if (e.region == REGION_CACHED) begin
      e.hit = m_valid[idx] && (m_tag[idx] == tag);
      // Misses allocate the line
      if (!e.hit) begin
        m_valid[idx] = 1'b1;
        m_tag[idx] = tag;
      end
      m_cnt[{we, !e.hit}] = m_cnt[{we, !e.hit}] + 32'd1;
    end else begin
      e.hit = (e.region == REGION_SPM);
    end
    stim[n_entries] = e;
    n_entries = n_entries + 1;
  endtask

  task automatic random_burst(input int count);
    logic [31:0]            r;
    logic [`LLC_ADDR_W-1:0] base;
    for (int k = 0; k < count; k++) begin
      r = $random(seed);
      // Lines 0/1 and 2/3 share an index
      case (r[10:8])
        3'd0:    base = 32'h8000_0000;
        3'd1:    base = 32'h8000_0200;
        3'd2:    base = 32'h8000_C020;
        3'd3:    base = 32'h8000_0420;
        3'd4:    base = 32'h8000_8040;
        3'd5:    base = 32'h2000_0000;
        3'd6:    base = 32'h8000_0000;
        default: base = 32'h8000_F3E0;
      endcase
      issue_request(base | {27'd0, r[4:0]}, r[16]);
    end
  endtask

  task automatic build_table();
    n_entries = 0;
    m_cache_start = '0;
    m_cache_end = '0;
    m_spm_start = '0;
    for (int i = 0; i < `LLC_NUM_LINES; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      m_cnt[i] = '0;
    end
    // Windows at reset
    issue_request(32'h0000_2000, 1'b0);
    issue_request(32'h8000_0040, 1'b1);
    issue_request(32'hFFFF_FFE0, 1'b0);
    read_counters();
    read_register(REG_FLUSH);
    // SPM window sits inside the cache window
    write_register(REG_CACHE_START, 32'h8000_0000);
    write_register(REG_CACHE_END, 32'h8001_0000);
    write_register(REG_SPM_START, 32'h8000_8000);
    read_register(REG_CACHE_START);
    read_register(REG_CACHE_END);
    read_register(REG_SPM_START);
    write_register(REG_READ_MISS, 32'hDEAD_BEEF);
    read_register(REG_READ_MISS);
    issue_request(32'h7FFF_FFFF, 1'b0);
    issue_request(32'h8000_0000, 1'b0);
    issue_request(32'h8000_7FFF, 1'b1);
    issue_request(32'h8000_8000, 1'b0);
    issue_request(32'h8000_8FFF, 1'b1);
    issue_request(32'h8000_9000, 1'b0);
    issue_request(32'h8000_FFFF, 1'b1);
    issue_request(32'h8001_0000, 1'b0);
    issue_request(32'h1000_0000, 1'b1);
    // Same line, then eviction on index 8, then back to back on one index
    issue_request(32'h8000_0100, 1'b0);
    issue_request(32'h8000_0104, 1'b1);
    issue_request(32'h8000_011C, 1'b0);
    issue_request(32'h8000_0300, 1'b0);
    issue_request(32'h8000_0100, 1'b0);
    issue_request(32'h8000_0300, 1'b1);
    issue_request(32'h8000_0500, 1'b0);
    issue_request(32'h8000_0504, 1'b1);
    issue_request(32'h8000_0100, 1'b1);
    issue_request(32'h8000_0108, 1'b0);
    read_counters();
    random_burst(24);
    read_counters();
    issue_request(32'h2000_0040, 1'b0);
    issue_request(32'h8000_8100, 1'b1);
    issue_request(32'h4000_0000, 1'b1);
    read_counters();
    write_register(REG_FLUSH, 32'h0000_0001);
    read_counters();
    issue_request(32'h8000_0100, 1'b0);
    read_register(REG_READ_MISS);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    cfg_req_valid = 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    next_cycle();
    if (e.kind == KIND_REQ) begin
      while (spent - returned >= `LLC_REQ_CREDITS) begin
        next_cycle();
      end
      req_valid = 1'b1;
      req_addr = e.addr;
      req_we = e.we;
      exp_region = e.region;
      exp_hit = e.hit;
      spent = spent + 1;
    end else begin
      // Config accesses wait until the request pipeline is empty
      while (returned != spent) begin
        next_cycle();
      end
      cfg_req_valid = 1'b1;
      cfg_we = (e.kind == KIND_CFG_WR);
      cfg_addr = e.reg_idx;
      cfg_wdata = e.data;
      exp_rdata = e.data;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_addr = '0;
    req_we = 1'b0;
    cfg_req_valid = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = REG_CACHE_START;
    cfg_wdata = '0;
    exp_region = REGION_BYPASS;
    exp_hit = 1'b0;
    exp_rdata = '0;
    seed = 32'h9904;
    build_table();
    cycle_limit = 4 * n_entries + 64;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < n_entries; i++) begin
      apply_entry(stim[i]);
    end
    next_cycle();
    while ((pending != 0) || (returned != spent)) begin
      next_cycle();
    end
    $display("Errors: value %0d, protocol %0d", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tests/llc_checker.sv
// LLC response checker comparing DUT responses and config read data with expected values
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_checker (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  llc_pkg::llc_region_e   exp_region_i,
  input  logic                   exp_hit_i,
  input  logic                   cfg_req_valid_i,
  input  logic                   cfg_we_i,
  input  logic [`LLC_ADDR_W-1:0] exp_rdata_i,
  input  logic                   resp_valid_i,
  input  llc_pkg::llc_region_e   resp_region_i,
  input  logic                   resp_hit_i,
  input  logic                   credit_i,
  input  logic                   cfg_resp_valid_i,
  input  logic [`LLC_ADDR_W-1:0] cfg_rdata_i,
  output int                     value_errs_o,
  output int                     proto_errs_o,
  output int                     pending_o
);
  import llc_pkg::*;

  // Expected responses in request order
  logic [1:0]             region_q [$];
  logic                   hit_q [$];
  int                     issue_q [$];
  logic                   rd_q [$];
  logic [`LLC_ADDR_W-1:0] rdata_q [$];
  int                     cycle = 0;
  int                     value_errs = 0;
  int                     proto_errs = 0;
  int                     pending = 0;

  // Sampled mid-cycle where DUT outputs and driven inputs are settled
  always @(negedge clk_i) begin
    logic [1:0]             exp_region;
    logic                   exp_hit;
    int                     issued;
    logic                   exp_rd;
    logic [`LLC_ADDR_W-1:0] exp_rdata;
    cycle = cycle + 1;
    if (rst_n_i) begin
      if (credit_i !== resp_valid_i) begin
        proto_errs = proto_errs + 1;
        $display("Credit return and response valid disagree at cycle %0d", cycle);
      end
      if (resp_valid_i === 1'b1) begin
        if (hit_q.size() == 0) begin
          proto_errs = proto_errs + 1;
          $display("Response at cycle %0d with no request outstanding", cycle);
        end else begin
          exp_region = region_q.pop_front();
          exp_hit = hit_q.pop_front();
          issued = issue_q.pop_front();
          if (resp_region_i !== exp_region) begin
            value_errs = value_errs + 1;
            $display("Fail resp_region_o: expected 0x%h got 0x%h", exp_region, resp_region_i);
          end
          if (resp_hit_i !== exp_hit) begin
            value_errs = value_errs + 1;
            $display("Fail resp_hit_o: expected 0x%h got 0x%h", exp_hit, resp_hit_i);
          end
          if (cycle - issued != 2) begin
            proto_errs = proto_errs + 1;
            $display("Response came %0d cycles after its request instead of 2", cycle - issued);
          end
        end
      end
      if (cfg_resp_valid_i === 1'b1) begin
        if (rd_q.size() == 0) begin
          proto_errs = proto_errs + 1;
          $display("Config response at cycle %0d with no access outstanding", cycle);
        end else begin
          exp_rd = rd_q.pop_front();
          exp_rdata = rdata_q.pop_front();
          if (exp_rd && (cfg_rdata_i !== exp_rdata)) begin
            value_errs = value_errs + 1;
            $display("Fail cfg_rdata_o: expected 0x%h got 0x%h", exp_rdata, cfg_rdata_i);
          end
        end
      end
      if (req_valid_i === 1'b1) begin
        region_q.push_back(exp_region_i);
        hit_q.push_back(exp_hit_i);
        issue_q.push_back(cycle);
      end
      if (cfg_req_valid_i === 1'b1) begin
        rd_q.push_back(!cfg_we_i);
        rdata_q.push_back(exp_rdata_i);
      end
    end
    pending = hit_q.size() + rd_q.size();
  end

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;
  assign pending_o    = pending;

endmodule

//--- logic/llc_monitor_top.sv
// LLC monitor top level joining region decoder, tag store, event unit and config
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_monitor_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Request port
  input  logic                    req_valid_i,
  input  logic [`LLC_ADDR_W-1:0]  req_addr_i,
  input  logic                    req_we_i,
  // Response port
  output logic                    resp_valid_o,
  output llc_pkg::llc_region_e    resp_region_o,
  output logic                    resp_hit_o,
  output logic                    credit_o,
  // Configuration port
  input  logic                    cfg_req_valid_i,
  input  logic                    cfg_we_i,
  input  llc_pkg::llc_cfg_reg_e   cfg_addr_i,
  input  logic [`LLC_ADDR_W-1:0]  cfg_wdata_i,
  output logic                    cfg_resp_valid_o,
  output logic [`LLC_ADDR_W-1:0]  cfg_rdata_o
);
  import llc_pkg::*;

  llc_region_e            region;
  logic                   region_valid;
  logic                   lookup_hit;
  logic                   alloc;
  logic                   flush;
  logic [`LLC_ADDR_W-1:0] cache_start;
  logic [`LLC_ADDR_W-1:0] cache_end;
  logic [`LLC_ADDR_W-1:0] spm_start;
  logic [`LLC_CNT_W-1:0]  read_hit;
  logic [`LLC_CNT_W-1:0]  read_miss;
  logic [`LLC_CNT_W-1:0]  write_hit;
  logic [`LLC_CNT_W-1:0]  write_miss;

  llc_region_decoder region_decoder_i (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .req_valid_i   ( req_valid_i  ),
    .req_addr_i    ( req_addr_i   ),
    .cache_start_i ( cache_start  ),
    .cache_end_i   ( cache_end    ),
    .spm_start_i   ( spm_start    ),
    .region_o      ( region       ),
    .valid_o       ( region_valid )
  );

  llc_tag_store tag_store_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_addr_i  ( req_addr_i  ),
    .alloc_i     ( alloc       ),
    .flush_i     ( flush       ),
    .hit_o       ( lookup_hit  )
  );

  llc_event_unit event_unit_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .valid_i       ( region_valid  ),
    .we_i          ( req_we_i      ),
    .region_i      ( region        ),
    .hit_i         ( lookup_hit    ),
    .flush_i       ( flush         ),
    .alloc_o       ( alloc         ),
    .resp_valid_o  ( resp_valid_o  ),
    .resp_region_o ( resp_region_o ),
    .resp_hit_o    ( resp_hit_o    ),
    .credit_o      ( credit_o      ),
    .read_hit_o    ( read_hit      ),
    .read_miss_o   ( read_miss     ),
    .write_hit_o   ( write_hit     ),
    .write_miss_o  ( write_miss    )
  );

  llc_cfg_regs cfg_regs_i (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .cfg_req_valid_i  ( cfg_req_valid_i  ),
    .cfg_we_i         ( cfg_we_i         ),
    .cfg_addr_i       ( cfg_addr_i       ),
    .cfg_wdata_i      ( cfg_wdata_i      ),
    .cfg_resp_valid_o ( cfg_resp_valid_o ),
    .cfg_rdata_o      ( cfg_rdata_o      ),
    .cache_start_o    ( cache_start      ),
    .cache_end_o      ( cache_end        ),
    .spm_start_o      ( spm_start        ),
    .flush_o          ( flush            ),
    .read_hit_i       ( read_hit         ),
    .read_miss_i      ( read_miss        ),
    .write_hit_i      ( write_hit        ),
    .write_miss_i     ( write_miss       )
  );

endmodule

//--- logic/llc_cfg_regs.sv
// LLC configuration registers for windows, counter readback and tag flush
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_cfg_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cfg_req_valid_i,
  input  logic                    cfg_we_i,
  input  llc_pkg::llc_cfg_reg_e   cfg_addr_i,
  input  logic [`LLC_ADDR_W-1:0]  cfg_wdata_i,
  output logic                    cfg_resp_valid_o,
  output logic [`LLC_ADDR_W-1:0]  cfg_rdata_o,
  output logic [`LLC_ADDR_W-1:0]  cache_start_o,
  output logic [`LLC_ADDR_W-1:0]  cache_end_o,
  output logic [`LLC_ADDR_W-1:0]  spm_start_o,
  output logic                    flush_o,
  input  logic [`LLC_CNT_W-1:0]   read_hit_i,
  input  logic [`LLC_CNT_W-1:0]   read_miss_i,
  input  logic [`LLC_CNT_W-1:0]   write_hit_i,
  input  logic [`LLC_CNT_W-1:0]   write_miss_i
);
  import llc_pkg::*;

  logic [`LLC_ADDR_W-1:0] cache_start_q;
  logic [`LLC_ADDR_W-1:0] cache_end_q;
  logic [`LLC_ADDR_W-1:0] spm_start_q;
  logic [`LLC_ADDR_W-1:0] rdata_d;
  logic [`LLC_ADDR_W-1:0] rdata_q;
  logic                   resp_valid_q;
  logic                   wr_en;

  assign wr_en = cfg_req_valid_i && cfg_we_i;

  // Flush acts at the edge that samples the write
  assign flush_o = wr_en && (cfg_addr_i == REG_FLUSH);

  always_comb begin
    case (cfg_addr_i)
      REG_CACHE_START: rdata_d = cache_start_q;
      REG_CACHE_END:   rdata_d = cache_end_q;
      REG_SPM_START:   rdata_d = spm_start_q;
      REG_READ_HIT:    rdata_d = read_hit_i;
      REG_READ_MISS:   rdata_d = read_miss_i;
      REG_WRITE_HIT:   rdata_d = write_hit_i;
      REG_WRITE_MISS:  rdata_d = write_miss_i;
      default:         rdata_d = '0;
    endcase
  end

  // Counters are read only, so only the windows take writes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      spm_start_q   <= '0;
      resp_valid_q  <= 1'b0;
    end else begin
      resp_valid_q <= cfg_req_valid_i;
      if (wr_en && (cfg_addr_i == REG_CACHE_START)) begin
        cache_start_q <= cfg_wdata_i;
      end
      if (wr_en && (cfg_addr_i == REG_CACHE_END)) begin
        cache_end_q <= cfg_wdata_i;
      end
      if (wr_en && (cfg_addr_i == REG_SPM_START)) begin
        spm_start_q <= cfg_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign cfg_resp_valid_o = resp_valid_q;
  assign cfg_rdata_o      = rdata_q;
  assign cache_start_o    = cache_start_q;
  assign cache_end_o      = cache_end_q;
  assign spm_start_o      = spm_start_q;

endmodule

//--- logic/llc_event_unit.sv
// LLC event unit forming responses, credits, allocations and hit/miss counters
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_event_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  logic                   we_i,
  input  llc_pkg::llc_region_e   region_i,
  input  logic                   hit_i,
  input  logic                   flush_i,
  output logic                   alloc_o,
  output logic                   resp_valid_o,
  output llc_pkg::llc_region_e   resp_region_o,
  output logic                   resp_hit_o,
  output logic                   credit_o,
  output logic [`LLC_CNT_W-1:0]  read_hit_o,
  output logic [`LLC_CNT_W-1:0]  read_miss_o,
  output logic [`LLC_CNT_W-1:0]  write_hit_o,
  output logic [`LLC_CNT_W-1:0]  write_miss_o
);
  import llc_pkg::*;

  logic                  we_q;
  logic                  cached;
  logic                  resp_hit_d;
  logic [3:0]            evt;
  logic                  resp_valid_q;
  logic                  credit_q;
  llc_region_e           resp_region_q;
  logic                  resp_hit_q;
  logic [`LLC_CNT_W-1:0] cnt_q [4];

  // Write bit aligned with the stage one results
  always_ff @(posedge clk_i) begin
    we_q <= we_i;
  end

  assign cached  = valid_i && (region_i == REGION_CACHED);
  assign alloc_o = cached && !hit_i;

  // SPM always hits, bypass never does
  assign resp_hit_d = (region_i == REGION_SPM) || ((region_i == REGION_CACHED) && hit_i);

  assign evt[0] = cached && !we_q && hit_i;
  assign evt[1] = cached && !we_q && !hit_i;
  assign evt[2] = cached && we_q && hit_i;
  assign evt[3] = cached && we_q && !hit_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
      credit_q     <= 1'b0;
    end else begin
      resp_valid_q <= valid_i;
      credit_q     <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_region_q <= region_i;
    resp_hit_q    <= resp_hit_d;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (evt[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign resp_valid_o  = resp_valid_q;
  assign resp_region_o = resp_region_q;
  assign resp_hit_o    = resp_hit_q;
  assign credit_o      = credit_q;
  assign read_hit_o    = cnt_q[0];
  assign read_miss_o   = cnt_q[1];
  assign write_hit_o   = cnt_q[2];
  assign write_miss_o  = cnt_q[3];

  // A flush never meets a request in stage one
  a_no_flush_in_flight: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> !valid_i
  ) else $error("flush arrived while a request was in flight");

endmodule

//--- logic/llc_tag_store.sv
// LLC tag store, direct-mapped tag model with lookup, allocation and flush
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_tag_store (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  logic [`LLC_ADDR_W-1:0]  req_addr_i,
  input  logic                    alloc_i,
  input  logic                    flush_i,
  output logic                    hit_o
);

  logic [`LLC_NUM_LINES-1:0] valid_q;
  logic [`LLC_TAG_W-1:0]     tag_mem [`LLC_NUM_LINES];

  logic [`LLC_INDEX_W-1:0]   req_idx;
  logic [`LLC_TAG_W-1:0]     req_tag;
  logic                      fwd;
  logic                      lookup_hit;

  // Index and tag of the request being looked up
  logic [`LLC_INDEX_W-1:0]   idx_q;
  logic [`LLC_TAG_W-1:0]     tag_q;
  logic                      hit_q;

  assign req_idx = req_addr_i[`LLC_OFFSET_W +: `LLC_INDEX_W];
  assign req_tag = req_addr_i[`LLC_ADDR_W-1 -: `LLC_TAG_W];

  // Allocation landing this cycle on the same line
  assign fwd = alloc_i && (idx_q == req_idx);

  always_comb begin
    if (flush_i) begin
      lookup_hit = 1'b0;
    end else if (fwd) begin
      lookup_hit = (tag_q == req_tag);
    end else begin
      lookup_hit = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      hit_q   <= 1'b0;
    end else begin
      hit_q <= req_valid_i && lookup_hit;
      if (flush_i) begin
        valid_q <= '0;
      end else if (alloc_i) begin
        valid_q[idx_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      idx_q <= req_idx;
      tag_q <= req_tag;
    end
    if (alloc_i) begin
      tag_mem[idx_q] <= tag_q;
    end
  end

  assign hit_o = hit_q;

  // Event unit only allocates for the request looked up one cycle earlier
  a_alloc_after_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    alloc_i |-> $past(req_valid_i)
  ) else $error("allocation without a preceding request");

endmodule

//--- logic/llc_region_decoder.sv
// LLC region decoder classifying request addresses against cache and SPM windows
`timescale 1ns/1ps
`include "llc_params.svh"

module llc_region_decoder (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  logic [`LLC_ADDR_W-1:0]  req_addr_i,
  input  logic [`LLC_ADDR_W-1:0]  cache_start_i,
  input  logic [`LLC_ADDR_W-1:0]  cache_end_i,
  input  logic [`LLC_ADDR_W-1:0]  spm_start_i,
  output llc_pkg::llc_region_e    region_o,
  output logic                    valid_o
);
  import llc_pkg::*;

  // One extra bit so the SPM end never wraps
  logic [`LLC_ADDR_W:0] spm_end;
  logic                 in_spm;
  logic                 in_cache;
  llc_region_e          region_d;
  llc_region_e          region_q;
  logic                 valid_q;

  assign spm_end  = {1'b0, spm_start_i} + (`LLC_ADDR_W+1)'(`LLC_SPM_SIZE);
  assign in_spm   = (req_addr_i >= spm_start_i) && ({1'b0, req_addr_i} < spm_end);
  assign in_cache = (req_addr_i >= cache_start_i) && (req_addr_i < cache_end_i);

  // SPM takes priority over the cached window
  always_comb begin
    if (in_spm) begin
      region_d = REGION_SPM;
    end else if (in_cache) begin
      region_d = REGION_CACHED;
    end else begin
      region_d = REGION_BYPASS;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    region_q <= region_d;
  end

  assign region_o = region_q;
  assign valid_o  = valid_q;

endmodule

//--- logic/llc_pkg.sv
// LLC monitor package with region and configuration register types
package llc_pkg;

  // Address region of a request
  typedef enum logic [1:0] {
    REGION_BYPASS = 2'd0,
    REGION_CACHED = 2'd1,
    REGION_SPM    = 2'd2
  } llc_region_e;

  // Configuration register index
  typedef enum logic [2:0] {
    REG_CACHE_START = 3'd0,
    REG_CACHE_END   = 3'd1,
    REG_SPM_START   = 3'd2,
    REG_READ_HIT    = 3'd3,
    REG_READ_MISS   = 3'd4,
    REG_WRITE_HIT   = 3'd5,
    REG_WRITE_MISS  = 3'd6,
    REG_FLUSH       = 3'd7
  } llc_cfg_reg_e;

endpackage

//--- logic/llc_params.svh
// LLC monitor parameters for address, tag, counter and credit sizing
`ifndef LLC_PARAMS_SVH
`define LLC_PARAMS_SVH

// Request and configuration data width
`define LLC_ADDR_W 32

// Line geometry of the direct-mapped tag model
`define LLC_OFFSET_W 5
`define LLC_NUM_LINES 16
`define LLC_INDEX_W 4
`define LLC_TAG_W (`LLC_ADDR_W - `LLC_INDEX_W - `LLC_OFFSET_W)

// Scratchpad window size in bytes
`define LLC_SPM_SIZE 4096

// Requester credits after reset and event counter width
`define LLC_REQ_CREDITS 3
`define LLC_CNT_W 32

`endif
